/* Bender.yml */
package:
  name: exe_cluster

sources:
  - include_dirs:
      - .
    files:
      - exe_pkg.sv
      - reg_file.sv
      - issue_unit.sv
      - alu_lane.sv
      - writeback_unit.sv
      - exe_cluster.sv
  - target: test
    include_dirs:
      - .
    files:
      - exe_cluster_checker.sv
      - exe_cluster_tb.sv

/* alu_lane.sv */
// Two-stage integer ALU lane
`timescale 1ns/1ps
`include "exe_defs.svh"

module alu_lane import exe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  lane_req_t   req,
    output com_bundle_t res
);

    lane_req_t        s1;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] result;

    // stage one
    always_ff @(posedge clk) begin
        s1 <= req;
        if (rst) begin
            s1.valid <= 1'b0;
        end
    end

    always_comb begin
        shamt = s1.op_b[5:0];
        case (s1.op)
            alu_add:  result = s1.op_a + s1.op_b;
            alu_sub:  result = s1.op_a - s1.op_b;
            alu_sll:  result = s1.op_a << shamt;
            alu_slt:  result = `XLEN'($signed(s1.op_a) < $signed(s1.op_b));
            alu_sltu: result = `XLEN'(s1.op_a < s1.op_b);
            alu_xor:  result = s1.op_a ^ s1.op_b;
            alu_srl:  result = s1.op_a >> shamt;
            alu_sra:  result = $signed(s1.op_a) >>> shamt;
            alu_or:   result = s1.op_a | s1.op_b;
            default:  result = s1.op_a & s1.op_b;
        endcase
        if (s1.illegal) begin
            result = '0;
        end
    end

    // stage two
    always_ff @(posedge clk) begin
        res.opid    <= s1.opid;
        res.rd      <= s1.rd;
        res.illegal <= s1.illegal;
        res.result  <= result;
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= s1.valid;
        end
    end

endmodule

/* exe_cluster.sv */
// Integer execution cluster top
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_cluster import exe_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  iss_bundle_t             iss_in,
    output logic                    iss_ready,
    output com_bundle_t [`EWD-1:0]  com_out,
    output logic [31:0]             done_count
);

    lane_req_t   [`EWD-1:0]            lane_req;
    com_bundle_t [`EWD-1:0]            lane_res;
    logic [`REG_W-1:0]                 rd_idx_a, rd_idx_b;
    logic [`XLEN-1:0]                  rd_data_a, rd_data_b;
    logic [`NREG-1:0]                  busy;
    logic                              busy_set;
    logic [`REG_W-1:0]                 busy_idx;
    logic [`EWD-1:0]                   wr_en;
    logic [`EWD-1:0][`REG_W-1:0]       wr_idx;
    logic [`EWD-1:0][`XLEN-1:0]        wr_data;

    issue_unit issue_i (
        .clk(clk), .rst(rst),
        .iss_in(iss_in), .iss_ready(iss_ready),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .busy(busy), .busy_set(busy_set), .busy_idx(busy_idx),
        .lane_req(lane_req)
    );

    reg_file reg_file_i (
        .clk(clk), .rst(rst),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .busy_set(busy_set), .busy_idx(busy_idx),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .busy(busy)
    );

    // one ALU per lane
    for (genvar g = 0; g < `EWD; g++) begin : g_lane
        alu_lane alu_lane_i (
            .clk(clk),
            .rst(rst),
            .req(lane_req[g]),
            .res(lane_res[g])
        );
    end

    writeback_unit writeback_i (
        .clk(clk), .rst(rst),
        .lane_res(lane_res),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .com_out(com_out),
        .done_count(done_count)
    );

endmodule

/* exe_cluster_checker.sv */
// Cluster completion assertions
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_cluster_checker import exe_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input iss_bundle_t            iss_in,
    input logic                   iss_ready,
    input com_bundle_t [`EWD-1:0] com_out
);

    logic [`OPID_W-1:0] opid_pipe [4];
    logic [`EWD-1:0]    com_valid;
    logic               hit, dup;

    always_ff @(posedge clk) begin
        opid_pipe[0] <= iss_in.opid;
        for (int s = 1; s < 4; s++) begin
            opid_pipe[s] <= opid_pipe[s-1];
        end
    end

    always_comb begin
        hit = 1'b0;
        dup = 1'b0;
        for (int l = 0; l < `EWD; l++) begin
            com_valid[l] = com_out[l].valid;
            hit = hit || (com_out[l].valid && com_out[l].opid == opid_pipe[3]);
            for (int m = l + 1; m < `EWD; m++) begin
                dup = dup || (com_out[l].valid && com_out[m].valid &&
                              com_out[l].opid == com_out[m].opid);
            end
        end
    end

    // com_out updates on the third edge, seen by the sample after it
    a_latency: assert property (@(posedge clk) disable iff (rst)
        (iss_in.valid && iss_ready) |-> ##4 hit)
        else $error("no completion 3 cycles after acceptance");

    a_reset: assert property (@(posedge clk) rst |=> (com_valid == '0))
        else $error("completion valid in the cycle after reset");

    a_unique: assert property (@(posedge clk) disable iff (rst) !dup)
        else $error("two lanes complete the same opid");

endmodule

bind exe_cluster exe_cluster_checker checker_i (
    .clk(clk), .rst(rst), .iss_in(iss_in), .iss_ready(iss_ready), .com_out(com_out)
);

/* exe_cluster_tb.sv */
// Execution cluster testbench
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_cluster_tb import exe_pkg::*; ();

    localparam int n_inst         = 400;
    localparam int accept_timeout = 20;
    localparam int drain_timeout  = 50;
    localparam int n_tags         = 1 << `OPID_W;
    localparam logic [6:0] opc_op  = 7'b0110011;
    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [31:0] probe_word = {7'b0, 5'd7, 5'd6, 3'd0, 5'd5, opc_op}; // add x5, x6, x7

    logic                   clk = 1'b0;
    logic                   rst;
    iss_bundle_t            iss_in;
    logic                   iss_ready;
    com_bundle_t [`EWD-1:0] com_out;
    logic [31:0]            done_count;

    logic [`XLEN-1:0]   model_regs [`NREG];
    logic [`NREG-1:0]   model_busy;
    logic               exp_pend [n_tags];   // indexed by opid
    logic [`REG_W-1:0]  exp_rd [n_tags];
    logic               exp_ill [n_tags];
    logic [`XLEN-1:0]   exp_res [n_tags];
    int                 exp_cyc [n_tags];
    int                 cyc = 0;
    int                 in_flight = 0;
    int                 n_accepted = 0;
    int                 n_completed = 0;
    logic [`OPID_W-1:0] next_opid = '0;

    exe_cluster exe_cluster_i (
        .clk(clk), .rst(rst),
        .iss_in(iss_in), .iss_ready(iss_ready),
        .com_out(com_out), .done_count(done_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1; // rising edge count

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic value_error(string name, logic [63:0] got, logic [63:0] exp);
        $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        stop_run();
    endtask

    task automatic plain_error(string what);
        $display("ERROR %s", what);
        stop_run();
    endtask

    function automatic logic [`XLEN-1:0] ref_alu(logic [2:0] f3, logic alt,
                                                 logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
        logic [5:0] sh;
        sh = b[5:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return `XLEN'($signed(a) < $signed(b));
            3'd3: return `XLEN'(a < b);
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic legal_word(inst_u w);
        if (w.r.opcode == opc_op) begin
            return w.r.funct7 == 7'b0 ||
                   (w.r.funct7 == 7'b0100000 && (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5));
        end
        if (w.i.opcode == opc_imm) begin
            if (w.i.funct3 == 3'd1) begin
                return w.i.imm12[11:6] == 6'b0;
            end
            if (w.i.funct3 == 3'd5) begin
                return w.i.imm12[11:6] == 6'b0 || w.i.imm12[11:6] == 6'b010000;
            end
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic inst_u random_word();
        inst_u       w;
        int          kind;
        logic        alt;
        logic [11:0] imm;
        kind     = $urandom_range(99, 0);
        w        = inst_u'($urandom);
        w.r.rd   = 5'($urandom_range(7, 0)); // x0..x7 keeps hazards frequent
        w.r.rs1  = 5'($urandom_range(7, 0));
        w.r.rs2  = 5'($urandom_range(7, 0));
        if (kind < 4) begin
            w.r.opcode[4] = 1'b0; // outside OP and OP-IMM
        end else if (kind < 7) begin
            w.r.opcode = opc_op;
            w.r.funct7 = 7'b0000001; // mul group
        end else if (kind < 10) begin
            w.r.opcode = opc_op;
            w.r.funct7 = 7'b0100000;
            w.r.funct3 = 3'd4;
        end else if (kind < 55) begin
            alt        = $urandom_range(1, 0) && (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5);
            w.r.opcode = opc_op;
            w.r.funct7 = alt ? 7'b0100000 : 7'b0;
        end else begin
            imm = 12'($urandom);
            if (w.i.funct3 == 3'd1) begin
                imm[11:6] = 6'b0;
            end
            if (w.i.funct3 == 3'd5) begin
                imm[11:6] = $urandom_range(1, 0) ? 6'b010000 : 6'b0;
            end
            w.i.opcode = opc_imm;
            w.i.imm12  = imm;
        end
        return w;
    endfunction

    // in-order execution of one accepted word
    task automatic model_accept(logic [`OPID_W-1:0] id, inst_u w);
        logic             is_r, ok, alt;
        logic [`XLEN-1:0] a, b, res;
        is_r = w.r.opcode == opc_op;
        ok   = legal_word(w);
        a    = model_regs[w.r.rs1];
        b    = is_r ? model_regs[w.r.rs2] : {{(`XLEN-12){w.i.imm12[11]}}, w.i.imm12};
        alt  = is_r ? w.r.funct7[5] : (w.i.funct3 == 3'd5 && w.i.imm12[10]);
        res  = ok ? ref_alu(w.r.funct3, alt, a, b) : '0;
        if (ok && w.r.rd != '0) begin
            model_regs[w.r.rd] = res;
            model_busy[w.r.rd] = 1'b1;
        end
        assert (!exp_pend[id]) else plain_error("opid reused while still in flight");
        exp_pend[id] = 1'b1;
        exp_rd[id]   = w.r.rd;
        exp_ill[id]  = !ok;
        exp_res[id]  = res;
        exp_cyc[id]  = cyc + 1;
        in_flight++;
        n_accepted++;
    endtask

    // ready is low while a legal word reads or writes a pending register
    task automatic check_ready(inst_u w);
        logic is_r, exp_rdy;
        is_r    = w.r.opcode == opc_op;
        exp_rdy = !legal_word(w) ||
                  !(model_busy[w.r.rs1] || (is_r && model_busy[w.r.rs2]) ||
                    (w.r.rd != '0 && model_busy[w.r.rd]));
        assert (iss_ready == exp_rdy) else value_error("iss_ready", iss_ready, exp_rdy);
    endtask

    task automatic wait_accept(inst_u w);
        int t;
        t = 0;
        #1;
        check_ready(w);
        while (!iss_ready) begin
            if (t >= accept_timeout) begin
                plain_error("instruction not accepted within timeout");
            end else begin
                t++;
                @(negedge clk);
                #1;
                check_ready(w);
            end
        end
    endtask

    task automatic check_completions();
        logic [`OPID_W-1:0] id;
        for (int l = 0; l < `EWD; l++) begin
            if (com_out[l].valid) begin
                id = com_out[l].opid;
                assert (exp_pend[id]) else plain_error("completion for an opid not in flight");
                assert (com_out[l].rd == exp_rd[id])
                    else value_error("com_out.rd", com_out[l].rd, exp_rd[id]);
                assert (com_out[l].illegal == exp_ill[id])
                    else value_error("com_out.illegal", com_out[l].illegal, exp_ill[id]);
                assert (com_out[l].result == exp_res[id])
                    else value_error("com_out.result", com_out[l].result, exp_res[id]);
                assert (cyc - exp_cyc[id] == 3)
                    else plain_error("completion did not arrive 3 cycles after acceptance");
                if (!exp_ill[id] && exp_rd[id] != '0) begin
                    model_busy[exp_rd[id]] = 1'b0;
                end
                exp_pend[id] = 1'b0;
                in_flight--;
                n_completed++;
            end
        end
        assert (done_count == 32'(n_completed))
            else value_error("done_count", done_count, n_completed);
    endtask

    // com_out is stable at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            check_completions();
        end
    end

    initial begin
        inst_u word;
        int    t;
        void'($urandom(32'h3b48));
        rst         = 1'b1;
        iss_in      = '0;
        iss_in.inst = inst_u'(probe_word);
        model_busy  = '0;
        for (int i = 0; i < n_tags; i++) begin
            exp_pend[i] = 1'b0;
        end
        for (int r = 0; r < `NREG; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        #1;
        assert (iss_ready) else plain_error("iss_ready low after reset");

        while (n_accepted < n_inst) begin
            @(negedge clk);
            word         = random_word();
            iss_in.inst  = word;
            iss_in.opid  = next_opid;
            iss_in.valid = $urandom_range(99, 0) >= 20; // random gaps
            if (iss_in.valid) begin
                wait_accept(word);
                model_accept(next_opid, word);
                next_opid++;
            end
        end

        @(negedge clk);
        iss_in.valid = 1'b0;
        iss_in.inst  = inst_u'(probe_word);
        t = 0;
        #1;
        while (in_flight != 0) begin
            if (t >= drain_timeout) begin
                plain_error("cluster did not drain within timeout");
            end else begin
                t++;
                @(negedge clk);
                #1;
            end
        end
        assert (done_count == 32'(n_accepted))
            else value_error("done_count", done_count, n_accepted);
        assert (iss_ready) else plain_error("iss_ready still low after drain");
        $display("Testbench passed");
        $finish;
    end

endmodule

/* exe_defs.svh */
// Execution cluster widths
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// datapath and register file
`define XLEN    64
`define NREG    32
`define REG_W   5

// operation tag
`define OPID_W  8

// ALU lanes, LANE_W must cover EWD-1
`define EWD     2
`define LANE_W  1

`endif

/* exe_pkg.sv */
// Execution cluster types
`include "exe_defs.svh"

package exe_pkg;

    // R-type instruction layout
    typedef struct packed {
        logic [6:0]        funct7;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [`REG_W-1:0] rd;
        logic [6:0]        opcode;
    } inst_r_t;

    // I-type instruction layout
    typedef struct packed {
        logic [11:0]       imm12;
        logic [`REG_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [`REG_W-1:0] rd;
        logic [6:0]        opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef struct packed {
        logic               valid;
        logic [`OPID_W-1:0] opid;
        inst_u              inst;
    } iss_bundle_t;

    typedef struct packed {
        logic               valid;
        logic [`OPID_W-1:0] opid;
        alu_op_e            op;
        logic [`REG_W-1:0]  rd;
        logic               illegal;
        logic [`XLEN-1:0]   op_a;
        logic [`XLEN-1:0]   op_b;
    } lane_req_t;

    typedef struct packed {
        logic               valid;
        logic [`OPID_W-1:0] opid;
        logic [`REG_W-1:0]  rd;
        logic               illegal;
        logic [`XLEN-1:0]   result;
    } com_bundle_t;

endpackage

/* files.f */
+incdir+.
exe_pkg.sv
reg_file.sv
issue_unit.sv
alu_lane.sv
writeback_unit.sv
exe_cluster.sv
exe_cluster_checker.sv
exe_cluster_tb.sv

/* issue_unit.sv */
// Decode, hazard check and lane dispatch
`timescale 1ns/1ps
`include "exe_defs.svh"

module issue_unit import exe_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  iss_bundle_t              iss_in,
    output logic                     iss_ready,
    output logic [`REG_W-1:0]        rd_idx_a,
    output logic [`REG_W-1:0]        rd_idx_b,
    input  logic [`XLEN-1:0]         rd_data_a,
    input  logic [`XLEN-1:0]         rd_data_b,
    input  logic [`NREG-1:0]         busy,
    output logic                     busy_set,
    output logic [`REG_W-1:0]        busy_idx,
    output lane_req_t [`EWD-1:0]     lane_req
);

    localparam logic [6:0] opc_op  = 7'b0110011;
    localparam logic [6:0] opc_imm = 7'b0010011;

    logic              is_r, is_i, legal, alt;
    logic              hazard, accept;
    logic [2:0]        funct3;
    logic [`REG_W-1:0] rd;
    logic [`XLEN-1:0]  imm;
    alu_op_e           op;
    logic [`LANE_W-1:0] rr_ptr;

    always_comb begin
        is_r   = iss_in.inst.r.opcode == opc_op;
        is_i   = iss_in.inst.i.opcode == opc_imm;
        funct3 = iss_in.inst.r.funct3; // same bits in both formats
        rd     = iss_in.inst.r.rd;
        imm    = {{(`XLEN-12){iss_in.inst.i.imm12[11]}}, iss_in.inst.i.imm12};
        alt    = 1'b0;
        legal  = 1'b0;
        if (is_r) begin
            alt   = iss_in.inst.r.funct7[5];
            legal = iss_in.inst.r.funct7 == 7'b0000000 ||
                    (iss_in.inst.r.funct7 == 7'b0100000 &&
                     (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (is_i) begin
            if (funct3 == 3'b001) begin
                legal = iss_in.inst.i.imm12[11:6] == 6'b000000; // slli
            end else if (funct3 == 3'b101) begin
                alt   = iss_in.inst.i.imm12[10];                // srai
                legal = iss_in.inst.i.imm12[11:6] == 6'b000000 ||
                        iss_in.inst.i.imm12[11:6] == 6'b010000;
            end else begin
                legal = 1'b1;
            end
        end
        case (funct3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
    end

    // operand reads and scoreboard
    always_comb begin
        rd_idx_a  = iss_in.inst.i.rs1;
        rd_idx_b  = iss_in.inst.r.rs2;
        hazard    = legal && (busy[rd_idx_a] || (is_r && busy[rd_idx_b]) ||
                              (rd != '0 && busy[rd]));
        iss_ready = !hazard;
        accept    = iss_in.valid && iss_ready;
        busy_set  = accept && legal && rd != '0;
        busy_idx  = rd;
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `EWD; l++) begin
            lane_req[l].valid   <= accept && rr_ptr == `LANE_W'(l);
            lane_req[l].opid    <= iss_in.opid;
            lane_req[l].op      <= op;
            lane_req[l].rd      <= rd;
            lane_req[l].illegal <= !legal;
            lane_req[l].op_a    <= rd_data_a;
            lane_req[l].op_b    <= is_r ? rd_data_b : imm;
        end
        if (rst) begin
            for (int l = 0; l < `EWD; l++) begin
                lane_req[l].valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (accept) begin
            rr_ptr <= (rr_ptr == `LANE_W'(`EWD-1)) ? '0 : rr_ptr + 1'b1; // wrap at last lane
        end
    end

endmodule

/* reg_file.sv */
// Integer register file and scoreboard
`timescale 1ns/1ps
`include "exe_defs.svh"

module reg_file (
    input  logic                           clk,
    input  logic                           rst,
    // issue side reads
    input  logic [`REG_W-1:0]              rd_idx_a,
    input  logic [`REG_W-1:0]              rd_idx_b,
    output logic [`XLEN-1:0]               rd_data_a,
    output logic [`XLEN-1:0]               rd_data_b,
    // scoreboard set from issue
    input  logic                           busy_set,
    input  logic [`REG_W-1:0]              busy_idx,
    // one write port per lane
    input  logic [`EWD-1:0]                wr_en,
    input  logic [`EWD-1:0][`REG_W-1:0]    wr_idx,
    input  logic [`EWD-1:0][`XLEN-1:0]     wr_data,
    output logic [`NREG-1:0]               busy
);

    logic [`XLEN-1:0] regs [`NREG];

    // x0 is hardwired
    always_comb begin
        rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
        rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NREG; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < `EWD; l++) begin
                if (wr_en[l] && wr_idx[l] != '0) begin
                    regs[wr_idx[l]] <= wr_data[l];
                end
            end
        end
    end

    // clears first, a set never hits a register still in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            for (int l = 0; l < `EWD; l++) begin
                if (wr_en[l]) begin
                    busy[wr_idx[l]] <= 1'b0;
                end
            end
            if (busy_set && busy_idx != '0) begin
                busy[busy_idx] <= 1'b1;
            end
        end
    end

endmodule

/* writeback_unit.sv */
// Lane result writeback and completion
`timescale 1ns/1ps
`include "exe_defs.svh"

module writeback_unit import exe_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  com_bundle_t [`EWD-1:0]        lane_res,
    output logic [`EWD-1:0]               wr_en,
    output logic [`EWD-1:0][`REG_W-1:0]   wr_idx,
    output logic [`EWD-1:0][`XLEN-1:0]    wr_data,
    output com_bundle_t [`EWD-1:0]        com_out,
    output logic [31:0]                   done_count
);

    logic [`LANE_W:0] n_done;

    // register write lands on the same edge as com_out
    always_comb begin
        n_done = '0;
        for (int l = 0; l < `EWD; l++) begin
            wr_en[l]   = lane_res[l].valid && !lane_res[l].illegal && lane_res[l].rd != '0;
            wr_idx[l]  = lane_res[l].rd;
            wr_data[l] = lane_res[l].result;
            n_done     = n_done + (`LANE_W+1)'(lane_res[l].valid);
        end
    end

    always_ff @(posedge clk) begin
        com_out <= lane_res;
        if (rst) begin
            for (int l = 0; l < `EWD; l++) begin
                com_out[l].valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_count <= '0;
        end else begin
            done_count <= done_count + 32'(n_done); // up to EWD per cycle
        end
    end

endmodule
